// ==== up_params.svh ====
`ifndef UP_PARAMS_SVH
`define UP_PARAMS_SVH

// Datapath and bus widths
`define UP_DATA_W 8
`define UP_ADDR_W 8

// Number of bytes in the unified program and data memory
`define UP_MEM_DEPTH 256

// Address where every start begins fetching
`define UP_START_PC 0

// Bytes per instruction, opcode then operand
`define UP_INSTR_LEN 2

`endif

// ==== upPkg.sv ====
`include "up_params.svh"

package upPkg;

	typedef enum logic [3:0] {
		OP_NOP = 4'd0,
		OP_LDI = 4'd1,
		OP_LDA = 4'd2,
		OP_STA = 4'd3,
		OP_ADD = 4'd4,
		OP_SUB = 4'd5,
		OP_AND = 4'd6,
		OP_OR  = 4'd7,
		OP_XOR = 4'd8,
		OP_SHL = 4'd9,
		OP_SHR = 4'd10,
		OP_JMP = 4'd11,
		OP_JZ  = 4'd12,
		OP_JC  = 4'd13,
		OP_HLT = 4'd14 // Code 15 halts as well
	} upOpcode;

	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		OPERAND,
		EXECUTE,
		HALT
	} upState;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SHL,
		ALU_SHR,
		ALU_PASS
	} upAluOp;

	typedef struct packed {
		logic [`UP_ADDR_W-1:0] address;
		logic [`UP_DATA_W-1:0] wdata;
		logic we;
	} upBusReq;

	typedef struct packed {
		logic zero;
		logic carry;
	} upFlags;

endpackage

// ==== upMemory.sv ====
`timescale 1ns/1ps
`include "up_params.svh"

module upMemory (
	input logic clk,
	input logic nRst,
	input upPkg::upBusReq req,
	output logic [`UP_DATA_W-1:0] rdata
);

	localparam int bootLen = 8;

	// LDI 0x5A, STA 0x80, ADD 0x80, HLT
	localparam logic [`UP_DATA_W-1:0] bootImage [bootLen] = '{
		8'h01, 8'h5A,
		8'h03, 8'h80,
		8'h04, 8'h80,
		8'h0F, 8'h00
	};

	logic [`UP_DATA_W-1:0] mem [`UP_MEM_DEPTH];

	assign rdata = mem[req.address]; // Combinational read in the same cycle

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < `UP_MEM_DEPTH; i++) begin
				mem[i] <= '0;
			end
			for (int i = 0; i < bootLen; i++) begin
				mem[i] <= bootImage[i]; // Later assignment wins over the clear
			end
		end else if (req.we) begin
			mem[req.address] <= req.wdata;
		end
	end

	// A write to an unknown address would corrupt an unknown byte
	writeAddrKnown: assert property (
		@(posedge clk) disable iff (!nRst)
		req.we |-> !$isunknown(req.address)
	);

endmodule

// ==== upAlu.sv ====
`timescale 1ns/1ps
`include "up_params.svh"

module upAlu (
	input upPkg::upAluOp op,
	input logic [`UP_DATA_W-1:0] a,
	input logic [`UP_DATA_W-1:0] b,
	output logic [`UP_DATA_W-1:0] result,
	output upPkg::upFlags flags
);
	import upPkg::*;

	logic [`UP_DATA_W:0] wide; // Top bit is the carry, the borrow or the shifted-out bit

	always_comb begin
		wide = {1'b0, b};
		case (op)
			ALU_ADD: begin
				wide = {1'b0, a} + {1'b0, b};
			end
			ALU_SUB: begin
				wide = {1'b0, a} - {1'b0, b}; // Wraps into bit 8 when a borrow occurs
			end
			ALU_AND: begin
				wide = {1'b0, a & b};
			end
			ALU_OR: begin
				wide = {1'b0, a | b};
			end
			ALU_XOR: begin
				wide = {1'b0, a ^ b};
			end
			ALU_SHL: begin
				wide = {a, 1'b0};
			end
			ALU_SHR: begin
				wide = {a[0], 1'b0, a[`UP_DATA_W-1:1]};
			end
			ALU_PASS: begin
				wide = {1'b0, b};
			end
		endcase
	end

	always_comb begin
		result = wide[`UP_DATA_W-1:0];
		flags.zero = (wide[`UP_DATA_W-1:0] == '0);
		flags.carry = wide[`UP_DATA_W]; // Logic ops and pass always give zero here
	end

endmodule

// ==== upCore.sv ====
`timescale 1ns/1ps
`include "up_params.svh"

module upCore (
	input logic clk,
	input logic nRst,
	input logic start,
	input upPkg::upBusReq hostReq,
	output upPkg::upBusReq memReq,
	input logic [`UP_DATA_W-1:0] rdata,
	output upPkg::upAluOp aluOp,
	output logic [`UP_DATA_W-1:0] aluA,
	output logic [`UP_DATA_W-1:0] aluB,
	input logic [`UP_DATA_W-1:0] aluResult,
	input upPkg::upFlags aluFlags,
	output logic [`UP_DATA_W-1:0] acc,
	output upPkg::upFlags flags,
	output logic busy,
	output logic halted
);
	import upPkg::*;

	upState state;
	upOpcode ir;
	logic [`UP_ADDR_W-1:0] pc;
	logic [`UP_DATA_W-1:0] opr;

	logic loadAcc; // Accumulator and zero flag update
	logic loadCarry;
	logic storeAcc;
	logic jump;
	logic halt;

	assign busy = (state == FETCH) || (state == OPERAND) || (state == EXECUTE);
	assign halted = (state == HALT);

	assign aluA = acc;
	assign aluB = (ir == OP_LDI) ? opr : rdata; // Immediate or memory at the operand address

	// Instruction decode
	always_comb begin
		aluOp = ALU_PASS;
		loadAcc = 1'b0;
		loadCarry = 1'b0;
		storeAcc = 1'b0;
		jump = 1'b0;
		halt = 1'b0;
		case (ir)
			OP_NOP: ;
			OP_LDI, OP_LDA: begin
				loadAcc = 1'b1;
			end
			OP_STA: begin
				storeAcc = 1'b1;
			end
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR: begin
				loadAcc = 1'b1;
				loadCarry = 1'b1;
				case (ir)
					OP_ADD: aluOp = ALU_ADD;
					OP_SUB: aluOp = ALU_SUB;
					OP_AND: aluOp = ALU_AND;
					OP_OR: aluOp = ALU_OR;
					OP_XOR: aluOp = ALU_XOR;
					OP_SHL: aluOp = ALU_SHL;
					default: aluOp = ALU_SHR;
				endcase
			end
			OP_JMP: begin
				jump = 1'b1;
			end
			OP_JZ: begin
				jump = flags.zero; // Tested on the stored flags
			end
			OP_JC: begin
				jump = flags.carry;
			end
			default: begin
				halt = 1'b1; // Codes 14 and 15
			end
		endcase
	end

	// The core owns the memory port except while idle or halted
	always_comb begin
		case (state)
			FETCH: begin
				memReq = '{address: pc, wdata: acc, we: 1'b0};
			end
			OPERAND: begin
				memReq = '{address: pc + `UP_ADDR_W'(1), wdata: acc, we: 1'b0};
			end
			EXECUTE: begin
				memReq = '{address: opr, wdata: acc, we: storeAcc};
			end
			default: begin
				memReq = hostReq;
			end
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= IDLE;
			pc <= '0;
			acc <= '0;
			flags <= '0;
		end else begin
			case (state)
				IDLE, HALT: begin
					if (start) begin
						state <= FETCH;
						pc <= `UP_ADDR_W'(`UP_START_PC);
					end
				end
				FETCH: begin
					state <= OPERAND;
				end
				OPERAND: begin
					state <= EXECUTE;
				end
				EXECUTE: begin
					state <= halt ? HALT : FETCH;
					pc <= jump ? opr : pc + `UP_ADDR_W'(`UP_INSTR_LEN);
					if (loadAcc) begin
						acc <= aluResult;
						flags.zero <= aluFlags.zero;
					end
					if (loadCarry) begin
						flags.carry <= aluFlags.carry;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Instruction and operand bytes are captured straight off the read port
	always_ff @(posedge clk) begin
		if (state == FETCH) begin
			ir <= upOpcode'(rdata[3:0]); // High nibble is ignored
		end
		if (state == OPERAND) begin
			opr <= rdata;
		end
	end

	hostWriteIdle: assert property (
		@(posedge clk) disable iff (!nRst)
		busy |-> !hostReq.we
	);

	oneState: assert property (
		@(posedge clk) disable iff (!nRst)
		$onehot({state == IDLE, busy, halted})
	);

	pcKnown: assert property (
		@(posedge clk) disable iff (!nRst)
		busy |-> !$isunknown(pc)
	);

endmodule

// ==== upSystem.sv ====
`timescale 1ns/1ps
`include "up_params.svh"

module upSystem (
	input logic clk,
	input logic nRst,
	input logic start,
	input upPkg::upBusReq hostReq,
	output logic [`UP_DATA_W-1:0] hostRdata,
	output logic [`UP_DATA_W-1:0] acc,
	output upPkg::upFlags flags,
	output logic busy,
	output logic halted
);
	import upPkg::*;

	upBusReq memReq;
	upAluOp aluOp;
	logic [`UP_DATA_W-1:0] aluA;
	logic [`UP_DATA_W-1:0] aluB;
	logic [`UP_DATA_W-1:0] aluResult;
	upFlags aluFlags;

	upCore uCore (
		.clk(clk),
		.nRst(nRst),
		.start(start),
		.hostReq(hostReq),
		.memReq(memReq),
		.rdata(hostRdata), // Read data is shared with the host port
		.aluOp(aluOp),
		.aluA(aluA),
		.aluB(aluB),
		.aluResult(aluResult),
		.aluFlags(aluFlags),
		.acc(acc),
		.flags(flags),
		.busy(busy),
		.halted(halted)
	);

	upAlu uAlu (
		.op(aluOp),
		.a(aluA),
		.b(aluB),
		.result(aluResult),
		.flags(aluFlags)
	);

	upMemory uMemory (
		.clk(clk),
		.nRst(nRst),
		.req(memReq),
		.rdata(hostRdata)
	);

endmodule

// ==== tbUpSystem.sv ====
`timescale 1ns/1ps
`include "up_params.svh"

module tbUpSystem;
	import upPkg::*;

	localparam int clkPeriod = 40;
	localparam int cyclesPerLine = 800;

	logic clk;
	logic nRst;
	logic start;
	upBusReq hostReq;
	logic [`UP_DATA_W-1:0] hostRdata;
	logic [`UP_DATA_W-1:0] acc;
	upFlags flags;
	logic busy;
	logic halted;

	string lines[$];
	string testName = "none";
	int lineCount = 0;
	logic [31:0] lcgState = 32'h8d0d0059;

	upSystem DUT (
		.clk(clk),
		.nRst(nRst),
		.start(start),
		.hostReq(hostReq),
		.hostRdata(hostRdata),
		.acc(acc),
		.flags(flags),
		.busy(busy),
		.halted(halted)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// All driving happens 2 ns after a rising edge, where outputs are also settled
	task automatic nextCycle();
		@(posedge clk);
		#2;
	endtask

	task automatic checkByte(input string what, input logic [`UP_DATA_W-1:0] expected,
			input logic [`UP_DATA_W-1:0] actual);
		if (actual !== expected) begin
			failRun($sformatf("ERR %s %s: expected 0x%02h, actual 0x%02h",
				testName, what, expected, actual));
		end
	endtask

	task automatic checkFlags(input string what, input upFlags expected, input upFlags actual);
		if (actual !== expected) begin
			failRun($sformatf("ERR %s %s: expected zero=%b carry=%b, actual zero=%b carry=%b",
				testName, what, expected.zero, expected.carry, actual.zero, actual.carry));
		end
	endtask

	task automatic checkState(input logic expBusy, input logic expHalted);
		if (busy !== expBusy || halted !== expHalted) begin
			failRun($sformatf("ERR %s state: expected busy=%b halted=%b, actual busy=%b halted=%b",
				testName, expBusy, expHalted, busy, halted));
		end
	endtask

	task automatic checkCount(input string what, input int expected, input int actual);
		if (actual != expected) begin
			failRun($sformatf("ERR %s %s: expected %0d, actual %0d",
				testName, what, expected, actual));
		end
	endtask

	task automatic applyReset();
		nRst = 1'b0;
		start = 1'b0;
		hostReq = '0;
		repeat (3) nextCycle();
		nRst = 1'b1;
	endtask

	task automatic hostWrite(input logic [`UP_ADDR_W-1:0] addr, input logic [`UP_DATA_W-1:0] data);
		hostReq = '{address: addr, wdata: data, we: 1'b1};
		nextCycle();
		hostReq.we = 1'b0;
	endtask

	// Address is held across an edge so the combinational read has settled
	task automatic hostRead(input logic [`UP_ADDR_W-1:0] addr, output logic [`UP_DATA_W-1:0] data);
		hostReq = '{address: addr, wdata: '0, we: 1'b0};
		nextCycle();
		data = hostRdata;
	endtask

	task automatic runProgram(input int expCycles);
		int cycles;
		start = 1'b1;
		nextCycle();
		start = 1'b0;
		cycles = 1;
		while (!halted) begin
			checkState(1'b1, 1'b0); // The core is busy until it halts
			nextCycle();
			cycles++;
		end
		checkCount("cycles to halt", expCycles, cycles);
	endtask

	task automatic randomTest(input int count);
		logic [`UP_DATA_W-1:0] model [int]; // Last byte written to each address
		logic [31:0] r;
		logic [`UP_DATA_W-1:0] got;
		for (int i = 0; i < count; i++) begin
			r = nextRandom();
			model[int'(r[23:16])] = r[15:8];
			hostWrite(r[23:16], r[15:8]);
		end
		foreach (model[a]) begin
			hostRead(8'(a), got);
			checkByte($sformatf("random read 0x%02h", 8'(a)), model[a], got);
		end
	endtask

	initial begin
		int fd;
		int count;
		string line;
		string args;
		logic [31:0] argA;
		logic [31:0] argB;
		logic [31:0] argC;
		logic [`UP_DATA_W-1:0] got;
		upFlags expFlags;
		nRst = 1'b0;
		start = 1'b0;
		hostReq = '0;
		fd = $fopen("upGolden.txt", "r");
		if (fd == 0) begin
			failRun("Could not open upGolden.txt for reading");
		end
		while ($fgets(line, fd) > 0) begin
			if (line.getc(0) != "#" && line.getc(0) != "\n") begin
				lines.push_back(line);
			end
		end
		$fclose(fd);
		if (lines.size() == 0) begin
			failRun("The golden file holds no commands");
		end
		lineCount = lines.size();
		applyReset();
		foreach (lines[i]) begin
			line = lines[i];
			args = line.substr(1, line.len() - 1);
			void'($sscanf(args, "%h %h %h", argA, argB, argC));
			case (line.getc(0))
				"T": testName = line.substr(2, line.len() - 2);
				"R": applyReset();
				"W": hostWrite(argA[7:0], argB[7:0]);
				"I": begin
					hostWrite(argA[7:0], argB[7:0]); // Opcode byte then operand byte
					hostWrite(argA[7:0] + 8'd1, argC[7:0]);
				end
				"C": begin
					hostRead(argA[7:0], got);
					checkByte($sformatf("read 0x%02h", argA[7:0]), argB[7:0], got);
				end
				"A": checkByte("accumulator", argA[7:0], acc);
				"F": begin
					expFlags.zero = argA[0];
					expFlags.carry = argB[0];
					checkFlags("flags", expFlags, flags);
				end
				"B": checkState(argA[0], argB[0]);
				"S": begin
					void'($sscanf(args, "%d", count));
					runProgram(count);
				end
				"X": begin
					void'($sscanf(args, "%d", count));
					randomTest(count);
				end
				default: failRun($sformatf("Unknown command in the golden file: %s", line));
			endcase
		end
		$display("Testbench passed");
		$finish;
	end

	// Generous bound of 800 clock cycles for every golden command
	initial begin
		wait (lineCount > 0);
		#(lineCount * cyclesPerLine * clkPeriod);
		$display("Timeout: the golden commands did not complete in the allowed time");
		$display("Testbench failed");
		$fatal(1, "Watchdog expired");
	end

endmodule

// ==== upGolden.txt ====
# Command letter, then hex arguments (S cycles and X count are decimal). T name, R reset,
# W addr data, I addr opcode operand, C addr byte, A acc, F zero carry, B busy halted
T resetImage
R
B 0 0
A 00
F 0 0
C 00 01
C 01 5A
C 02 03
C 03 80
C 04 04
C 05 80
C 06 0F
C 07 00
S 13
B 0 1
A B4
F 0 0
C 80 5A
T randomMemory
X 40
T arithmetic
R
I 00 01 F0
I 02 04 10
I 04 0F 00
W 10 20
S 10
A 10
F 0 1
I 04 05 11
I 06 0F 00
W 11 10
S 13
A 00
F 1 0
T logicShift
R
I 00 01 C3
I 02 06 20
I 04 07 21
I 06 03 30
I 08 08 22
I 0A 09 00
I 0C 03 31
I 0E 0A 00
I 10 0A 00
I 12 0F 00
W 20 0F
W 21 80
W 22 FE
S 31
A 3E
F 0 1
C 30 83
C 31 FA
T controlFlow
R
I 00 01 03
I 02 05 40
I 04 0C 08
I 06 0B 02
I 08 05 40
I 0A 0D 0E
I 0C 0F 00
I 0E 03 41
I 10 0F 00
W 40 01
S 40
A FF
F 0 1
C 41 FF
B 0 1

// ==== sources.f ====
+incdir+.
upPkg.sv
upMemory.sv
upAlu.sv
upCore.sv
upSystem.sv
tbUpSystem.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --timing --assert -j 0 --top-module tbUpSystem -f sources.f -o simUpSystem
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simUpSystem > "$logFile" 2>&1
simStatus=$?
cat "$logFile"

if grep -q "Testbench failed" "$logFile"; then
	exit 1
fi
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi
exit 0
